//--- verilog/board_io_pkg.sv
//////////////////////////////////////////////////
// shared types and constants of the board io block
// joystick chain steps and state struct
// i2s sample and word types, slot enum
// default divider and led hold settings
//////////////////////////////////////////////////

package board_io_pkg;

  //////////////////////////////////////////////////
  // widths
  localparam int AUDIO_SAMPLE_W = 15;           // chipset dac sample
  localparam int I2S_WORD_W     = 16;           // one i2s channel word
  localparam int JOY_STEP_W     = 4;            // chain step counter

  typedef logic [AUDIO_SAMPLE_W-1:0] audio_sample_t; // offset binary
  typedef logic [I2S_WORD_W-1:0]     i2s_word_t;     // two's complement, msb first

  //////////////////////////////////////////////////
  // joystick chain
  typedef struct packed {
    logic fire2;                                // all active low from chain
    logic fire1;
    logic up;
    logic down;
    logic left;
    logic right;
  } joy_state_t;

  typedef logic [7:0] joy_port_t;               // {2'b00, joy_state_t}

  typedef enum logic [1:0] {
    phase_load,                                 // step 0, load pulse low
    phase_skip,                                 // step 1, nothing valid yet
    phase_capture,                              // steps 2..13
    phase_idle                                  // step 14, end of frame
  } joy_phase_e;

  localparam int JOY_FRAME_STEPS     = 15;      // steps per chain frame
  localparam int JOY_CAP_FIRST       = 2;       // first capture step
  localparam int JOY_BITS_PER_PLAYER = 6;       // fire2 fire1 right left down up

  //////////////////////////////////////////////////
  // i2s slots
  typedef enum logic {
    slot_left,                                  // lrclk low
    slot_right                                  // lrclk high
  } i2s_slot_e;

  // defaults for the top level parameters
  localparam int JOY_DIV_BITS_DEFAULT = 3;      // joy_clk = clk_28 / 8
  localparam int SCLK_DIV_DEFAULT     = 4;      // clk_28 cycles per sclk half period
  localparam int LED_HOLD_DEFAULT     = 2**20;  // about 36 ms at 28 MHz

endpackage

//--- verilog/activity_if.sv
//////////////////////////////////////////////////
// disk activity pulses between sync and led logic
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface activity_if;

  logic floppy_wr_pulse;                        // one clk_28 cycle each
  logic floppy_rd_pulse;
  logic hd_wr_pulse;
  logic hd_rd_pulse;

  modport src (
    output floppy_wr_pulse, floppy_rd_pulse, hd_wr_pulse, hd_rd_pulse
  );

  modport dst (
    input  floppy_wr_pulse, floppy_rd_pulse, hd_wr_pulse, hd_rd_pulse
  );

endinterface

//--- verilog/joy_serial_reader.sv
//////////////////////////////////////////////////
// serial joystick chain reader
// makes joy_clk and joy_load for the shift chain
// captures both players bit by bit, active low
//////////////////////////////////////////////////

`timescale 1ns/1ps

module joy_serial_reader #(
  parameter int JOY_DIV_BITS = board_io_pkg::JOY_DIV_BITS_DEFAULT
) (
  input  logic                    clk_28,
  input  logic                    rst_n,
  input  logic                    joy_data,
  output logic                    joy_clk,
  output logic                    joy_load,
  output board_io_pkg::joy_state_t joy_p1,
  output board_io_pkg::joy_state_t joy_p2
);

  import board_io_pkg::*;

  localparam logic [JOY_STEP_W-1:0] LAST_STEP = JOY_STEP_W'(JOY_FRAME_STEPS - 1);
  localparam logic [JOY_STEP_W-1:0] CAP_FIRST = JOY_STEP_W'(JOY_CAP_FIRST);
  localparam logic [JOY_STEP_W-1:0] CAP_LAST  =
    JOY_STEP_W'(JOY_CAP_FIRST + 2 * JOY_BITS_PER_PLAYER - 1);
  localparam logic [JOY_STEP_W-1:0] PER_PLAYER = JOY_STEP_W'(JOY_BITS_PER_PLAYER);

  logic [JOY_DIV_BITS-1:0] div_cnt;             // free running chain divider
  logic [JOY_DIV_BITS-1:0] div_next;
  logic                    rise_tick;           // joy_clk rises at this edge
  logic [JOY_STEP_W-1:0]   step;                // 0..14
  logic [JOY_STEP_W-1:0]   step_next;
  logic [JOY_STEP_W-1:0]   cap_idx;             // 0..11 over both players
  joy_phase_e              phase;
  logic                    sample_bit;          // joy_data taken at the rise
  logic                    sample_pending;

  // step number to chain phase
  function automatic joy_phase_e phase_of(input logic [JOY_STEP_W-1:0] s);
    if (s == '0)
      return phase_load;
    else if (s < CAP_FIRST)
      return phase_skip;
    else if (s <= CAP_LAST)
      return phase_capture;
    else
      return phase_idle;
  endfunction

  // chain order per player: fire2 fire1 right left down up
  function automatic joy_state_t put_bit(input joy_state_t js,
                                         input logic [JOY_STEP_W-1:0] field,
                                         input logic b);
    joy_state_t r;
    r = js;
    case (field)
      4'd0:    r.fire2 = b;
      4'd1:    r.fire1 = b;
      4'd2:    r.right = b;
      4'd3:    r.left  = b;
      4'd4:    r.down  = b;
      default: r.up    = b;
    endcase
    return r;
  endfunction

  assign div_next  = div_cnt + 1'b1;
  assign rise_tick = div_next[JOY_DIV_BITS-1] & ~div_cnt[JOY_DIV_BITS-1]; // msb 0 -> 1
  assign step_next = (step == LAST_STEP) ? '0 : step + 1'b1;
  assign cap_idx   = step - CAP_FIRST;

  assign joy_clk  = div_cnt[JOY_DIV_BITS-1];    // top bit of the divider
  assign joy_load = (phase != phase_load);      // low only in step 0

  //////////////////////////////////////////////////
  // divider, step counter and phase
  always_ff @(posedge clk_28 or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt        <= '0;
      step           <= LAST_STEP;              // first rise starts step 0
      phase          <= phase_idle;
      sample_pending <= 1'b0;
    end else begin
      div_cnt        <= div_next;
      sample_pending <= rise_tick;              // commit one cycle later
      if (rise_tick) begin
        step  <= step_next;
        phase <= phase_of(step_next);
      end
    end
  end

  always_ff @(posedge clk_28) begin
    if (rise_tick)
      sample_bit <= joy_data;                   // bit for the step that starts now
  end

  //////////////////////////////////////////////////
  // route the sampled bit to its player
  always_ff @(posedge clk_28 or negedge rst_n) begin
    if (!rst_n) begin
      joy_p1 <= '1;                             // released
      joy_p2 <= '1;
    end else if (sample_pending && phase == phase_capture) begin
      if (cap_idx < PER_PLAYER)
        joy_p1 <= put_bit(joy_p1, cap_idx, sample_bit);
      else
        joy_p2 <= put_bit(joy_p2, cap_idx - PER_PLAYER, sample_bit);
    end
  end

endmodule

//--- verilog/activity_sync.sv
//////////////////////////////////////////////////
// disk activity strobe synchronizer
// two flop sync plus rising edge pulse per strobe
//////////////////////////////////////////////////

`timescale 1ns/1ps

module activity_sync (
  input  logic clk_28,
  input  logic rst_n,
  input  logic floppy_wr,
  input  logic floppy_rd,
  input  logic hd_wr,
  input  logic hd_rd,
  activity_if.src act
);

  localparam int FWR = 3;                       // bit positions in the vectors
  localparam int FRD = 2;
  localparam int HWR = 1;
  localparam int HRD = 0;

  logic [3:0] strobe_in;                        // foreign clock domain
  logic [3:0] sync_1;                           // metastability stage
  logic [3:0] sync_2;
  logic [3:0] edge_q;                           // previous synced level
  logic [3:0] pulse_q;                          // one cycle rising edge

  assign strobe_in = {floppy_wr, floppy_rd, hd_wr, hd_rd};

  always_ff @(posedge clk_28 or negedge rst_n) begin
    if (!rst_n) begin
      sync_1  <= '0;
      sync_2  <= '0;
      edge_q  <= '0;
      pulse_q <= '0;
    end else begin
      sync_1  <= strobe_in;
      sync_2  <= sync_1;
      edge_q  <= sync_2;
      pulse_q <= sync_2 & ~edge_q;              // low to high only
    end
  end

  assign act.floppy_wr_pulse = pulse_q[FWR];
  assign act.floppy_rd_pulse = pulse_q[FRD];
  assign act.hd_wr_pulse     = pulse_q[HWR];
  assign act.hd_rd_pulse     = pulse_q[HRD];

endmodule

//--- verilog/activity_leds.sv
//////////////////////////////////////////////////
// floppy and hard disk activity leds
// each pulse reloads a hold counter, led on while nonzero
//////////////////////////////////////////////////

`timescale 1ns/1ps

module activity_leds #(
  parameter int LED_HOLD_CYCLES = board_io_pkg::LED_HOLD_DEFAULT
) (
  input  logic    clk_28,
  input  logic    rst_n,
  activity_if.dst act,
  output logic    led_floppy,
  output logic    led_hd
);

  localparam int               CNT_W     = $clog2(LED_HOLD_CYCLES + 1);
  localparam logic [CNT_W-1:0] HOLD_LOAD = CNT_W'(LED_HOLD_CYCLES);
  localparam int               N_LEDS    = 2;
  localparam int               LED_FD    = 0;   // counter index floppy
  localparam int               LED_HDD   = 1;   // counter index hard disk

  logic [N_LEDS-1:0] hit;                       // any activity this cycle
  logic [CNT_W-1:0]  hold_cnt [N_LEDS];

  // reads and writes light the same led
  assign hit[LED_FD]  = act.floppy_wr_pulse | act.floppy_rd_pulse;
  assign hit[LED_HDD] = act.hd_wr_pulse | act.hd_rd_pulse;

  //////////////////////////////////////////////////
  // hold counters
  always_ff @(posedge clk_28 or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < N_LEDS; i++)
        hold_cnt[i] <= '0;
    end else begin
      for (int i = 0; i < N_LEDS; i++) begin
        if (hit[i])
          hold_cnt[i] <= HOLD_LOAD;             // retrigger extends the hold
        else if (hold_cnt[i] != '0)
          hold_cnt[i] <= hold_cnt[i] - 1'b1;
      end
    end
  end

  assign led_floppy = |hold_cnt[LED_FD];        // active high leds
  assign led_hd     = |hold_cnt[LED_HDD];

endmodule

//--- verilog/i2s_transmitter.sv
//////////////////////////////////////////////////
// i2s transmitter for the audio dac
// bit and word clocks divided from clk_28
// 15 bit offset binary samples sent as 16 bit words
//////////////////////////////////////////////////

`timescale 1ns/1ps

module i2s_transmitter #(
  parameter int SCLK_DIV = board_io_pkg::SCLK_DIV_DEFAULT
) (
  input  logic                       clk_28,
  input  logic                       rst_n,
  input  board_io_pkg::audio_sample_t audio_left,
  input  board_io_pkg::audio_sample_t audio_right,
  output logic                       sclk,
  output logic                       lrclk,
  output logic                       sdin
);

  import board_io_pkg::*;

  localparam int DIV_W = $clog2(SCLK_DIV + 1);
  localparam int BIT_W = $clog2(2 * I2S_WORD_W); // sclk periods per frame

  logic [DIV_W-1:0] div_cnt;                    // half period counter
  logic             div_end;
  logic             sclk_q;
  logic             sclk_fall;                  // sclk goes low at this edge
  logic [BIT_W-1:0] bit_cnt;                    // position in the 32 bit frame
  logic [BIT_W-1:0] bit_next;
  logic             slot_start;                 // lrclk changes now
  i2s_slot_e        slot;
  i2s_word_t        shreg;                      // outgoing word
  i2s_word_t        right_hold;                 // right word latched with left
  logic             sdin_q;

  // offset binary to two's complement, zero pad lsb
  function automatic i2s_word_t to_word(input audio_sample_t s);
    return {~s[AUDIO_SAMPLE_W-1], s[AUDIO_SAMPLE_W-2:0], 1'b0};
  endfunction

  assign div_end    = (div_cnt == DIV_W'(SCLK_DIV - 1));
  assign sclk_fall  = div_end & sclk_q;
  assign bit_next   = bit_cnt + 1'b1;
  assign slot_start = (bit_next[BIT_W-2:0] == '0);

  //////////////////////////////////////////////////
  // bit clock
  always_ff @(posedge clk_28 or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      sclk_q  <= 1'b0;
    end else if (div_end) begin
      div_cnt <= '0;
      sclk_q  <= ~sclk_q;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // word clock and data, all on sclk falling edges
  always_ff @(posedge clk_28 or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '1;                            // first fall opens a left slot
      slot    <= slot_left;
      shreg   <= '0;
      sdin_q  <= 1'b0;
    end else if (sclk_fall) begin
      bit_cnt <= bit_next;
      slot    <= bit_next[BIT_W-1] ? slot_right : slot_left;
      sdin_q  <= shreg[I2S_WORD_W-1];           // lsb of old word on slot change
      if (slot_start) begin
        if (!bit_next[BIT_W-1])
          shreg <= to_word(audio_left);         // frame start, lrclk falls
        else
          shreg <= right_hold;
      end else begin
        shreg <= shreg << 1;
      end
    end
  end

  // right sample taken at the same lrclk fall as the left one
  always_ff @(posedge clk_28) begin
    if (sclk_fall && bit_next == '0)
      right_hold <= to_word(audio_right);
  end

  assign sclk  = sclk_q;
  assign lrclk = (slot == slot_right);          // low for left
  assign sdin  = sdin_q;

endmodule

//--- verilog/board_io_top.sv
//////////////////////////////////////////////////
// board io top level
// joystick chain, disk activity leds, i2s dac output
// joystick ports swapped as on the board
//////////////////////////////////////////////////

`timescale 1ns/1ps

module board_io_top #(
  parameter int JOY_DIV_BITS    = board_io_pkg::JOY_DIV_BITS_DEFAULT,
  parameter int SCLK_DIV        = board_io_pkg::SCLK_DIV_DEFAULT,
  parameter int LED_HOLD_CYCLES = board_io_pkg::LED_HOLD_DEFAULT
) (
  input  logic                        clk_28,
  input  logic                        rst_n,
  // joystick chain
  input  logic                        joy_data,
  output logic                        joy_clk,
  output logic                        joy_load,
  output board_io_pkg::joy_port_t     joy1_port,   // mouse port byte
  output board_io_pkg::joy_port_t     joy2_port,   // joystick port byte
  // disk activity strobes, other clock domain
  input  logic                        floppy_wr,
  input  logic                        floppy_rd,
  input  logic                        hd_wr,
  input  logic                        hd_rd,
  output logic                        led_floppy,
  output logic                        led_hd,
  // audio
  input  board_io_pkg::audio_sample_t audio_left,
  input  board_io_pkg::audio_sample_t audio_right,
  output logic                        sclk,
  output logic                        lrclk,
  output logic                        sdin
);

  import board_io_pkg::*;

  joy_state_t joy_p1;                           // first player on the chain
  joy_state_t joy_p2;

  activity_if act_if ();

  //////////////////////////////////////////////////
  // input side
  joy_serial_reader #(
    .JOY_DIV_BITS (JOY_DIV_BITS)
  ) joy_serial_reader_inst (
    .clk_28   (clk_28),
    .rst_n    (rst_n),
    .joy_data (joy_data),
    .joy_clk  (joy_clk),
    .joy_load (joy_load),
    .joy_p1   (joy_p1),
    .joy_p2   (joy_p2)
  );

  assign joy1_port = {2'b00, joy_p2};           // player two on port 1
  assign joy2_port = {2'b00, joy_p1};           // player one on port 2

  activity_sync activity_sync_inst (
    .clk_28    (clk_28),
    .rst_n     (rst_n),
    .floppy_wr (floppy_wr),
    .floppy_rd (floppy_rd),
    .hd_wr     (hd_wr),
    .hd_rd     (hd_rd),
    .act       (act_if.src)
  );

  // leds and dac
  activity_leds #(
    .LED_HOLD_CYCLES (LED_HOLD_CYCLES)
  ) activity_leds_inst (
    .clk_28     (clk_28),
    .rst_n      (rst_n),
    .act        (act_if.dst),
    .led_floppy (led_floppy),
    .led_hd     (led_hd)
  );

  i2s_transmitter #(
    .SCLK_DIV (SCLK_DIV)
  ) i2s_transmitter_inst (
    .clk_28      (clk_28),
    .rst_n       (rst_n),
    .audio_left  (audio_left),
    .audio_right (audio_right),
    .sclk        (sclk),
    .lrclk       (lrclk),
    .sdin        (sdin)
  );

endmodule

//--- test/tb_clock_gen.sv
//////////////////////////////////////////////////
// testbench clock and reset source
// 10 ns clock, rst_n low for the first cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 5,               // ns
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;                            // release just after an edge
  end

endmodule

//--- test/board_io_chk.sv
//////////////////////////////////////////////////
// bound assertions on the board io outputs
// reset state, clock alignment
// led latency from the raw strobes
//////////////////////////////////////////////////

`timescale 1ns/1ps

module board_io_chk (
  input logic       clk_28,
  input logic       rst_n,
  input logic       joy_clk,
  input logic       joy_load,
  input logic [7:0] joy1_port,
  input logic [7:0] joy2_port,
  input logic       floppy_wr,
  input logic       floppy_rd,
  input logic       hd_wr,
  input logic       hd_rd,
  input logic       led_floppy,
  input logic       led_hd,
  input logic       sclk,
  input logic       lrclk,
  input logic       sdin
);

  //////////////////////////////////////////////////
  // state seen at the first edge after release
  a_reset_state: assert property (@(posedge clk_28)
    $rose(rst_n) |-> joy_load && !led_floppy && !led_hd && !sclk && !lrclk && !sdin
                     && joy1_port == 8'h3f && joy2_port == 8'h3f);

  // load edges only with a chain step
  a_load_step: assert property (@(posedge clk_28) disable iff (!rst_n)
    !$stable(joy_load) |-> $rose(joy_clk));

  //////////////////////////////////////////////////
  // i2s lines move on sclk falls only
  a_lrclk_fall: assert property (@(posedge clk_28) disable iff (!rst_n)
    !$stable(lrclk) |-> $fell(sclk));

  a_sdin_fall: assert property (@(posedge clk_28) disable iff (!rst_n)
    !$stable(sdin) |-> $fell(sclk));

  // sync, edge and counter load take 4 edges from the strobe
  a_floppy_latency: assert property (@(posedge clk_28) disable iff (!rst_n)
    $rose(led_floppy) |-> $past(floppy_wr || floppy_rd, 4));

  a_hd_latency: assert property (@(posedge clk_28) disable iff (!rst_n)
    $rose(led_hd) |-> $past(hd_wr || hd_rd, 4));

endmodule

//--- test/board_io_tb.sv
//////////////////////////////////////////////////
// board io testbench top
// DUT, joystick chain model, stimulus tasks
// immediate checks, timeout, closing summary
//////////////////////////////////////////////////

`timescale 1ns/1ps

module board_io_tb;

  import board_io_pkg::*;

  localparam int          LED_HOLD         = 64;
  localparam int          STEP_CYCLES      = 2 ** JOY_DIV_BITS_DEFAULT;
  localparam int          JOY_FRAME_CYCLES = JOY_FRAME_STEPS * STEP_CYCLES;
  localparam int          I2S_FRAME_CYCLES = 64 * SCLK_DIV_DEFAULT;  // 32 sclk periods
  localparam int          TIMEOUT_CYCLES   = 4 * JOY_FRAME_CYCLES + 6 * I2S_FRAME_CYCLES
                                             + 3 * (LED_HOLD + 10) + 600;
  localparam logic [31:0] SEED             = 32'hd6a5_bbae;

  logic          clk_28;
  logic          rst_n;
  logic          joy_data;
  logic          joy_clk;
  logic          joy_load;
  joy_port_t     joy1_port;
  joy_port_t     joy2_port;
  logic          floppy_wr;
  logic          floppy_rd;
  logic          hd_wr;
  logic          hd_rd;
  logic          led_floppy;
  logic          led_hd;
  audio_sample_t audio_left;
  audio_sample_t audio_right;
  logic          sclk;
  logic          lrclk;
  logic          sdin;

  logic [15:0]   pattern;                       // chain contents, bit n for step n
  int            model_step  = 0;
  logic          model_clk_d = 1'b0;
  int            cycles      = 0;
  int            checks      = 0;
  int            errors      = 0;

  tb_clock_gen clock_gen_inst (
    .clk   (clk_28),
    .rst_n (rst_n)
  );

  board_io_top #(
    .LED_HOLD_CYCLES (LED_HOLD)
  ) board_io_top_inst (
    .clk_28      (clk_28),
    .rst_n       (rst_n),
    .joy_data    (joy_data),
    .joy_clk     (joy_clk),
    .joy_load    (joy_load),
    .joy1_port   (joy1_port),
    .joy2_port   (joy2_port),
    .floppy_wr   (floppy_wr),
    .floppy_rd   (floppy_rd),
    .hd_wr       (hd_wr),
    .hd_rd       (hd_rd),
    .led_floppy  (led_floppy),
    .led_hd      (led_hd),
    .audio_left  (audio_left),
    .audio_right (audio_right),
    .sclk        (sclk),
    .lrclk       (lrclk),
    .sdin        (sdin)
  );

  bind board_io_top board_io_chk board_io_chk_inst (
    .clk_28     (clk_28),
    .rst_n      (rst_n),
    .joy_clk    (joy_clk),
    .joy_load   (joy_load),
    .joy1_port  (joy1_port),
    .joy2_port  (joy2_port),
    .floppy_wr  (floppy_wr),
    .floppy_rd  (floppy_rd),
    .hd_wr      (hd_wr),
    .hd_rd      (hd_rd),
    .led_floppy (led_floppy),
    .led_hd     (led_hd),
    .sclk       (sclk),
    .lrclk      (lrclk),
    .sdin       (sdin)
  );

  //////////////////////////////////////////////////
  // shift chain model, next bit ready before each rise
  always @(posedge clk_28) begin
    #1;
    if (joy_clk && !model_clk_d) begin
      if (!joy_load)
        model_step = 0;                         // load phase is step 0
      else
        model_step = model_step + 1;
      joy_data = pattern[(model_step + 1) % 16];
    end
    model_clk_d = joy_clk;
  end

  always @(posedge clk_28) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the run did not complete", cycles);
      $display("checks %0d errors %0d", checks, errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk_28);
    #1;                                         // outputs settled, inputs may change
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // chain order fire2 fire1 right left down up, byte order fire2 fire1 up down left right
  function automatic logic [7:0] port_byte(input logic [15:0] pat, input int first);
    return {2'b00, pat[first], pat[first + 1], pat[first + 5], pat[first + 4],
            pat[first + 3], pat[first + 2]};
  endfunction

  function automatic logic [15:0] expected_word(input logic [14:0] s);
    return {s ^ 15'h4000, 1'b0};                // sign flip, zero pad
  endfunction

  task automatic check_reset_state();
    check_value("joy_load", joy_load, 1'b1);
    check_value("led_floppy", led_floppy, 1'b0);
    check_value("led_hd", led_hd, 1'b0);
    check_value("lrclk", lrclk, 1'b0);
    check_value("sdin", sdin, 1'b0);
    check_value("joy1_port", joy1_port, 8'h3f);
    check_value("joy2_port", joy2_port, 8'h3f);
  endtask

  //////////////////////////////////////////////////
  // one chain frame from load to load
  task automatic run_joy_frame();
    int   low_cycles;
    int   high_steps;
    logic clk_d;
    while (joy_load)
      next_cycle();
    check_value("joy1_port", joy1_port, 8'h3f);  // nothing captured yet
    check_value("joy2_port", joy2_port, 8'h3f);
    low_cycles = 0;
    while (!joy_load) begin
      low_cycles++;
      next_cycle();
    end
    high_steps = 1;                             // step 1 just started
    while (joy_load) begin
      clk_d = joy_clk;
      next_cycle();
      if (joy_clk && !clk_d && joy_load)
        high_steps++;
    end
    check_value("joy_load low cycles", low_cycles, STEP_CYCLES);
    check_value("joy_load high steps", high_steps, JOY_FRAME_STEPS - 1);
    check_value("joy1_port", joy1_port, port_byte(pattern, 8));  // player two
    check_value("joy2_port", joy2_port, port_byte(pattern, 2));
  endtask

  task automatic set_strobe(input int which, input logic level);
    case (which)
      0:       floppy_wr = level;
      1:       floppy_rd = level;
      default: hd_rd     = level;
    endcase
  endtask

  // strobe, optional retrigger after gap cycles, then watch the hold run out
  task automatic run_led_case(input int which, input int gap);
    int   last;
    int   i;
    logic on_exp;
    last = 3 + LED_HOLD + gap;                  // last cycle with the led on
    set_strobe(which, 1'b1);
    for (i = 1; i <= last + 8; i++) begin
      next_cycle();
      on_exp = (i >= 4 && i <= last);
      if (which < 2) begin
        check_value("led_floppy", led_floppy, on_exp);
        check_value("led_hd", led_hd, 1'b0);
      end else begin
        check_value("led_hd", led_hd, on_exp);
        check_value("led_floppy", led_floppy, 1'b0);
      end
      if (i == 2 || (gap > 0 && i == gap + 2))
        set_strobe(which, 1'b0);
      else if (gap > 0 && i == gap)
        set_strobe(which, 1'b1);
    end
  endtask

  //////////////////////////////////////////////////
  // latch at the next lrclk fall, then read one frame
  task automatic run_i2s_frame(input logic [14:0] left, input logic [14:0] right);
    logic        lr_d;
    logic        sclk_d;
    logic [15:0] left_word;
    logic [15:0] right_word;
    int          idx;
    audio_left  = left;
    audio_right = right;
    lr_d = lrclk;
    next_cycle();
    while (!(lr_d && !lrclk)) begin
      lr_d = lrclk;
      next_cycle();
    end
    idx        = 0;                             // rise 0 carries the old lsb
    sclk_d     = sclk;
    left_word  = '0;
    right_word = '0;
    while (idx <= 32) begin
      next_cycle();
      if (sclk && !sclk_d) begin
        check_value("lrclk", lrclk, (idx >= 16 && idx < 32));
        if (idx >= 1 && idx <= 16)
          left_word = {left_word[14:0], sdin};
        else if (idx >= 17)
          right_word = {right_word[14:0], sdin};
        idx++;
      end
      sclk_d = sclk;
    end
    check_value("sdin left word", left_word, expected_word(left));
    check_value("sdin right word", right_word, expected_word(right));
  endtask

  initial begin
    void'($urandom(SEED));
    pattern     = 16'($urandom());
    joy_data    = 1'b1;
    floppy_wr   = 1'b0;
    floppy_rd   = 1'b0;
    hd_wr       = 1'b0;
    hd_rd       = 1'b0;
    audio_left  = '0;
    audio_right = '0;
    wait (rst_n === 1'b1);
    check_reset_state();
    run_joy_frame();
    run_led_case(0, 0);                         // floppy write
    run_led_case(1, 0);                         // floppy read
    run_led_case(2, 30);                        // hd read, retriggered
    run_i2s_frame(15'($urandom()), 15'($urandom()));
    run_i2s_frame(15'($urandom()), 15'($urandom()));
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- filelist.f
verilog/board_io_pkg.sv
verilog/activity_if.sv
verilog/joy_serial_reader.sv
verilog/activity_sync.sv
verilog/activity_leds.sv
verilog/i2s_transmitter.sv
verilog/board_io_top.sv
test/tb_clock_gen.sv
test/board_io_chk.sv
test/board_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the board io testbench with Verilator
set -e
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module board_io_tb -f filelist.f -o board_io_sim

# a failed bound assertion stops the simulator with a nonzero status
if ! ./obj_dir/board_io_sim > "$log" 2>&1; then
  cat "$log"
  echo "simulation stopped early"
  exit 1
fi
cat "$log"

if grep -q "ERRORS FOUND" "$log"; then
  echo "result: fail"
  exit 1
fi
echo "result: pass"
